// ==== Bender.yml ====
package:
  name: ps2_keyboard

sources:
  - rtl/ps2_pkg.sv
  - rtl/ps2_line_filter.sv
  - rtl/ps2_rx_ctrl.sv
  - rtl/ps2_frame_shift.sv
  - rtl/ps2_code_fifo.sv
  - rtl/ps2_wb_regs.sv
  - rtl/ps2_keyboard.sv
  - target: test
    files:
      - verification/ps2_keyboard_tb.sv

// ==== ps2_keyboard.f ====
rtl/ps2_pkg.sv
rtl/ps2_line_filter.sv
rtl/ps2_rx_ctrl.sv
rtl/ps2_frame_shift.sv
rtl/ps2_code_fifo.sv
rtl/ps2_wb_regs.sv
rtl/ps2_keyboard.sv
verification/ps2_keyboard_tb.sv

// ==== rtl/ps2_code_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_code_fifo #(
	parameter int depth_log2 = 3
) (
	input logic clk,
	input logic rst,
	input logic push,
	input ps2_pkg::ps2_frame_t wr_frame,
	input logic pop,
	input logic clear_overflow,
	output ps2_pkg::ps2_frame_t rd_frame,
	output logic empty,
	output logic [depth_log2:0] count,
	output logic overflow
);

	import ps2_pkg::*;

	localparam int depth = 1 << depth_log2;

	ps2_frame_t mem [depth];

	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;

	// The count never passes depth, so its top bit alone marks a full buffer.
	assign full = count[depth_log2];

	// A frame that arrives while full is lost, and a pop of nothing is ignored.
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// The head entry is always on the read port.
	assign rd_frame = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_frame;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// A push and a pop together leave the count unchanged.
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// A lost frame wins over a clear in the same cycle, so no loss goes unseen.
			if (push && full) begin
				overflow <= 1'b1;
			end else if (clear_overflow) begin
				overflow <= 1'b0;
			end
		end
	end

	count_bound: assert property (
		@(posedge clk) disable iff (rst)
		count <= depth
	);

endmodule

`default_nettype wire

// ==== rtl/ps2_frame_shift.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_frame_shift (
	input logic clk,
	input logic rst,
	input logic shift_en,
	input logic data_level,
	output ps2_pkg::ps2_frame_t frame
);

	import ps2_pkg::*;

	// Bits enter at the top and move toward bit 0.
	// After eleven shifts the start bit sits in bit 0 and the stop bit in bit 10.
	logic [frame_bits-1:0] shreg;

	always_ff @(posedge clk) begin
		if (rst) begin
			shreg <= '1;
		end else if (shift_en) begin
			shreg <= {data_level, shreg[frame_bits-1:1]};
		end
	end

	// Data bits were sent LSB first, so they land in order in bits 8 to 1.
	assign frame.code = shreg[8:1];

	// Odd parity over data and parity bit means their XOR must be 1.
	assign frame.parity_err = ~^shreg[9:1];

	// start must be 0 and stop must be 1
	assign frame.frame_err = shreg[0] | ~shreg[10];

endmodule

`default_nettype wire

// ==== rtl/ps2_keyboard.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_keyboard (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	input ps2_pkg::wb_m2s_t wb_in,
	output ps2_pkg::wb_s2m_t wb_out
);

	import ps2_pkg::*;

	logic data_level;
	logic fall;
	logic shift_en;
	logic push;
	ps2_frame_t frame;
	ps2_frame_t rd_frame;
	logic empty;
	logic [fifo_depth_log2:0] count;
	logic overflow;
	logic pop;
	logic clear_overflow;

	// Clean up the raw lines and find the PS/2 clock edges.
	ps2_line_filter u_filter (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.data_level(data_level),
		.fall(fall)
	);

	ps2_rx_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.fall(fall),
		.data_level(data_level),
		.shift_en(shift_en),
		.push(push)
	);

	ps2_frame_shift u_shift (
		.clk(clk),
		.rst(rst),
		.shift_en(shift_en),
		.data_level(data_level),
		.frame(frame)
	);

	// Received frames wait here until the host reads them.
	ps2_code_fifo #(
		.depth_log2(fifo_depth_log2)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.wr_frame(frame),
		.pop(pop),
		.clear_overflow(clear_overflow),
		.rd_frame(rd_frame),
		.empty(empty),
		.count(count),
		.overflow(overflow)
	);

	ps2_wb_regs u_regs (
		.clk(clk),
		.rst(rst),
		.wb_in(wb_in),
		.wb_out(wb_out),
		.rd_frame(rd_frame),
		.empty(empty),
		.count(count),
		.overflow(overflow),
		.pop(pop),
		.clear_overflow(clear_overflow)
	);

endmodule

`default_nettype wire

// ==== rtl/ps2_line_filter.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_line_filter (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output logic data_level,
	output logic fall
);

	import ps2_pkg::*;

	// Both lines are handled the same way, so they share arrays.
	// Index 0 is the PS/2 clock and index 1 is the PS/2 data line.
	logic [1:0] sync_a;
	logic [1:0] sync_b;
	logic [1:0] level;
	logic [1:0][debounce_cnt_w-1:0] stable_cnt;

	// Filtered clock level from the previous cycle, used for edge detection.
	logic clk_level_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			// The lines idle high with their pull-ups, so start from that state.
			sync_a <= 2'b11;
			sync_b <= 2'b11;
			level <= 2'b11;
			clk_level_q <= 1'b1;
			stable_cnt <= '0;
		end else begin
			// Two-flop synchronizer for the asynchronous inputs.
			sync_a <= {ps2_data, ps2_clk};
			sync_b <= sync_a;
			clk_level_q <= level[0];

			for (int i = 0; i < 2; i++) begin
				if (sync_b[i] == level[i]) begin
					// A line that agrees with its filtered level restarts the count.
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == debounce_cnt_w'(debounce_cycles - 1)) begin
					// The new value has held long enough, so it becomes the level.
					level[i] <= sync_b[i];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign data_level = level[1];

	// High in the first cycle the filtered clock reads 0 after reading 1.
	assign fall = clk_level_q & ~level[0];

endmodule

`default_nettype wire

// ==== rtl/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

	// A synchronized PS/2 line must hold its value this many clk cycles before the
	// filtered level follows it.
	localparam int debounce_cycles = 4;

	// A partial frame is dropped after this many clk cycles without a PS/2 clock fall.
	localparam int idle_timeout_cycles = 1000;

	// One PS/2 frame is start, eight data bits, odd parity and stop.
	localparam int frame_bits = 11;

	// Depth exponent of the scan-code FIFO as built in the top level.
	localparam int fifo_depth_log2 = 3;

	// Counter widths derived from the constants above.
	localparam int debounce_cnt_w = $clog2(debounce_cycles + 1);
	localparam int idle_cnt_w = $clog2(idle_timeout_cycles + 1);
	localparam int bit_cnt_w = $clog2(frame_bits);

	// Word addresses of the two host-visible registers.
	localparam logic [1:0] addr_data = 2'd0;
	localparam logic [1:0] addr_status = 2'd1;

	// One received frame as it is stored in the FIFO.
	// The frame_err bit flags a start bit of 1 or a stop bit of 0.
	typedef struct packed {
		logic [7:0] code;
		logic parity_err;
		logic frame_err;
	} ps2_frame_t;

	// Wishbone classic, master to slave.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] adr;
		logic [31:0] dat;
	} wb_m2s_t;

	// Wishbone classic, slave to master.
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_s2m_t;

endpackage

`default_nettype wire

// ==== rtl/ps2_rx_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_rx_ctrl (
	input logic clk,
	input logic rst,
	input logic fall,
	input logic data_level,
	output logic shift_en,
	output logic push
);

	import ps2_pkg::*;

	// Number of bits of the current frame already taken, 0 to frame_bits - 1.
	logic [bit_cnt_w-1:0] bit_cnt;

	// Cycles since the last PS/2 clock fall while a frame is in progress.
	logic [idle_cnt_w-1:0] idle_cnt;

	logic last_bit;
	logic frame_open;
	logic idle_expired;

	assign last_bit = bit_cnt == bit_cnt_w'(frame_bits - 1);
	assign frame_open = bit_cnt != '0;
	assign idle_expired = idle_cnt == idle_cnt_w'(idle_timeout_cycles);

	// Every falling edge of the PS/2 clock carries one bit into the shifter.
	// Alignment of the frame is kept by the bit counter, not by the shifter.
	assign shift_en = fall;

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
			push <= 1'b0;
		end else begin
			// The eleventh bit is shifted in this cycle.
			// The whole frame sits in the shifter one cycle later.
			push <= fall && last_bit;

			if (fall) begin
				idle_cnt <= '0;
				if (last_bit) begin
					bit_cnt <= '0;
				end else if (frame_open || !data_level) begin
					// A frame only opens on a low start bit.
					// A high one leaves the counter at 0, which resyncs after noise.
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (frame_open) begin
				if (idle_expired) begin
					// The keyboard went quiet mid-frame; throw the partial frame away.
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end else begin
				idle_cnt <= '0;
			end
		end
	end

	// The counter wraps on the last bit and never runs past the frame.
	bit_cnt_range: assert property (
		@(posedge clk) disable iff (rst)
		bit_cnt <= bit_cnt_w'(frame_bits - 1)
	);

	// Frames are at least eleven PS/2 clock periods apart, so pushes never touch.
	push_single: assert property (
		@(posedge clk) disable iff (rst)
		push |=> !push
	);

endmodule

`default_nettype wire

// ==== rtl/ps2_wb_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_wb_regs (
	input logic clk,
	input logic rst,
	input ps2_pkg::wb_m2s_t wb_in,
	output ps2_pkg::wb_s2m_t wb_out,
	input ps2_pkg::ps2_frame_t rd_frame,
	input logic empty,
	input logic [ps2_pkg::fifo_depth_log2:0] count,
	input logic overflow,
	output logic pop,
	output logic clear_overflow
);

	import ps2_pkg::*;

	logic ack;
	logic [31:0] rd_dat;
	logic req;
	logic rd_req;
	logic wr_req;

	// A new request is one the slave has not yet acknowledged.
	assign req = wb_in.cyc && wb_in.stb && !ack;
	assign rd_req = req && !wb_in.we;
	assign wr_req = req && wb_in.we;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			pop <= 1'b0;
			clear_overflow <= 1'b0;
		end else begin
			ack <= req;

			// Side effects line up with ack.
			// The FIFO moves at the end of the ack cycle, before the next request.
			pop <= rd_req && wb_in.adr == addr_data && !empty;
			clear_overflow <= wr_req && wb_in.adr == addr_status && wb_in.dat[8];
		end
	end

	// The read word is captured with the request and held while ack is high.
	always_ff @(posedge clk) begin
		if (req) begin
			rd_dat <= '0;
			if (!wb_in.we) begin
				case (wb_in.adr)
					addr_data: begin
						// Bit 31 marks a real entry, so an empty read is all zero.
						if (!empty) begin
							rd_dat[7:0] <= rd_frame.code;
							rd_dat[8] <= rd_frame.parity_err;
							rd_dat[9] <= rd_frame.frame_err;
							rd_dat[31] <= 1'b1;
						end
					end
					addr_status: begin
						rd_dat[7:0] <= 8'(count);
						rd_dat[8] <= overflow;
					end
					default: rd_dat <= '0;
				endcase
			end
		end
	end

	assign wb_out.ack = ack;
	assign wb_out.dat = rd_dat;

	// The master must hold its strobe until it has seen the ack.
	ack_in_cycle: assert property (
		@(posedge clk) disable iff (rst)
		ack |-> wb_in.cyc && wb_in.stb
	);

endmodule

`default_nettype wire

// ==== verification/ps2_keyboard_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module ps2_keyboard_tb;

	import ps2_pkg::*;

	// Half period of the modeled keyboard clock, in clk cycles.
	localparam int half_period = 20;

	// Limits for the waits on the DUT, in cycles or in status polls.
	localparam int bus_timeout = 20;
	localparam int poll_limit = 200;
	localparam int drain_limit = 100;

	logic clk;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	wb_m2s_t wb_in;
	wb_s2m_t wb_out;

	integer seed;

	// Reads wait here in order until the checker compares them.
	// A kind of 1 marks a status word and 0 marks a data word.
	bit kind_q[$];
	string name_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] got_q[$];
	int queued = 0;
	int checked = 0;

	// Codes of the burst that overruns the FIFO.
	logic [7:0] burst_codes [10];

	ps2_keyboard uut (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.wb_in(wb_in),
		.wb_out(wb_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Data register word for a stored frame.
	// Bad start frames are never stored, so only parity and stop faults appear here.
	function automatic logic [31:0] expected_entry(input logic [7:0] code,
		input logic bad_parity, input logic bad_stop);
		logic [31:0] word;
		word = '0;
		word[7:0] = code;
		word[8] = bad_parity;
		word[9] = bad_stop;
		word[31] = 1'b1;
		return word;
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "wait timed out");
	endtask

	task automatic check_data(input string name, input logic [31:0] exp_word,
		input logic [31:0] got_word);
		if (got_word !== exp_word) begin
			$display("Error: %s expected %h actual %h", name, exp_word, got_word);
			$display("TEST RESULT: FAIL");
			$fatal(1, "data register mismatch");
		end
	endtask

	task automatic check_status(input string name,
		input logic [fifo_depth_log2:0] exp_count, input logic exp_ovf,
		input logic [fifo_depth_log2:0] got_count, input logic got_ovf);
		if (got_count !== exp_count || got_ovf !== exp_ovf) begin
			$display("Error: %s expected count %0d overflow %0b actual count %0d overflow %0b",
				name, exp_count, exp_ovf, got_count, got_ovf);
			$display("TEST RESULT: FAIL");
			$fatal(1, "status register mismatch");
		end
	endtask

	function automatic void queue_data_check(input string name, input logic [31:0] exp_word,
		input logic [31:0] got_word);
		kind_q.push_back(1'b0);
		name_q.push_back(name);
		exp_q.push_back(exp_word);
		got_q.push_back(got_word);
		queued++;
	endfunction

	// The expected status is packed the way the status register lays it out.
	function automatic void queue_status_check(input string name,
		input logic [fifo_depth_log2:0] exp_count, input logic exp_ovf,
		input logic [31:0] got_word);
		kind_q.push_back(1'b1);
		name_q.push_back(name);
		exp_q.push_back({23'b0, exp_ovf, 8'(exp_count)});
		got_q.push_back(got_word);
		queued++;
	endfunction

	// Keyboard model.
	// Data changes while the PS/2 clock is high and is read by the DUT on the fall.
	// Fewer than frame_bits bits give a truncated frame.
	task automatic send_frame(input logic [7:0] code, input logic bad_parity,
		input logic bad_start, input logic bad_stop, input int nbits);
		logic [10:0] bits;
		bits[0] = bad_start;
		bits[8:1] = code;
		// Odd parity makes the ones in data and parity an odd number.
		bits[9] = ~^code ^ bad_parity;
		bits[10] = ~bad_stop;
		for (int i = 0; i < nbits; i++) begin
			ps2_data = bits[i];
			repeat (half_period) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (half_period) @(negedge clk);
			ps2_clk = 1'b1;
		end
		// The keyboard releases the data line once it is done.
		ps2_data = 1'b1;
		repeat (half_period) @(negedge clk);
	endtask

	task automatic idle_gap(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	// Wishbone classic master.
	// Strobe stays up through the cycle in which the slave raises ack.
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		wb_in.cyc = 1'b1;
		wb_in.stb = 1'b1;
		wb_in.we = we;
		wb_in.adr = adr;
		wb_in.dat = wdat;
		@(negedge clk);
		while (!wb_out.ack) begin
			waited++;
			if (waited > bus_timeout) begin
				report_timeout("the Wishbone slave never raised ack");
			end
			@(negedge clk);
		end
		rdat = wb_out.dat;
		@(negedge clk);
		wb_in = '0;
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	// Polls the status register until the FIFO holds at least n entries.
	task automatic wait_for_count(input int n);
		logic [31:0] status;
		int polls;
		polls = 0;
		read_reg(addr_status, status);
		while (status[7:0] < n) begin
			polls++;
			if (polls > poll_limit) begin
				report_timeout("the FIFO count never reached the expected fill");
			end
			read_reg(addr_status, status);
		end
	endtask

	// Compares every queued read against its expected word, in the order of the reads.
	initial begin : compare_reads
		bit kind;
		string name;
		logic [31:0] exp_word;
		logic [31:0] got_word;
		forever begin
			@(negedge clk);
			while (got_q.size() != 0) begin
				kind = kind_q.pop_front();
				name = name_q.pop_front();
				exp_word = exp_q.pop_front();
				got_word = got_q.pop_front();
				if (kind) begin
					check_status(name, exp_word[fifo_depth_log2:0], exp_word[8],
						got_word[fifo_depth_log2:0], got_word[8]);
				end else begin
					check_data(name, exp_word, got_word);
				end
				checked++;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] word;
		logic [7:0] code;
		int drain_wait;
		seed = 24;
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		wb_in = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);

		// Clean frames with random codes, each read back on its own.
		for (int i = 0; i < 20; i++) begin
			code = 8'($random(seed));
			send_frame(code, 1'b0, 1'b0, 1'b0, frame_bits);
			wait_for_count(1);
			read_reg(addr_data, word);
			queue_data_check("random_frame", expected_entry(code, 1'b0, 1'b0), word);
		end

		for (int i = 0; i < 3; i++) begin
			code = 8'($random(seed));
			send_frame(code, 1'b1, 1'b0, 1'b0, frame_bits);
			wait_for_count(1);
			read_reg(addr_data, word);
			queue_data_check("bad_parity", expected_entry(code, 1'b1, 1'b0), word);
		end

		// A high start bit never opens a full frame.
		// A later low data bit may open a short one, which the idle timeout drops.
		send_frame(8'h5a, 1'b0, 1'b1, 1'b0, frame_bits);
		idle_gap(idle_timeout_cycles + 100);
		read_reg(addr_status, word);
		queue_status_check("bad_start", '0, 1'b0, word);

		code = 8'($random(seed));
		send_frame(code, 1'b0, 1'b0, 1'b1, frame_bits);
		wait_for_count(1);
		read_reg(addr_data, word);
		queue_data_check("bad_stop", expected_entry(code, 1'b0, 1'b1), word);

		// Three bits, then silence, then a good frame that must come through whole.
		code = 8'($random(seed));
		send_frame(code, 1'b0, 1'b0, 1'b0, 3);
		idle_gap(idle_timeout_cycles + 100);
		code = 8'($random(seed));
		send_frame(code, 1'b0, 1'b0, 1'b0, frame_bits);
		wait_for_count(1);
		read_reg(addr_data, word);
		queue_data_check("after_timeout", expected_entry(code, 1'b0, 1'b0), word);
		read_reg(addr_status, word);
		queue_status_check("after_timeout_count", '0, 1'b0, word);

		// Ten frames into an eight-entry FIFO; the last two are lost.
		for (int i = 0; i < 10; i++) begin
			burst_codes[i] = 8'($random(seed));
			send_frame(burst_codes[i], 1'b0, 1'b0, 1'b0, frame_bits);
		end
		wait_for_count(8);
		read_reg(addr_status, word);
		queue_status_check("burst_status", 8, 1'b1, word);
		for (int i = 0; i < 8; i++) begin
			read_reg(addr_data, word);
			queue_data_check("burst_order", expected_entry(burst_codes[i], 1'b0, 1'b0), word);
		end
		write_reg(addr_status, 32'h0000_0100);
		read_reg(addr_status, word);
		queue_status_check("overflow_clear", '0, 1'b0, word);

		// An empty FIFO reads as all zero and does not move the count.
		read_reg(addr_data, word);
		queue_data_check("empty_read", 32'h0, word);
		read_reg(addr_status, word);
		queue_status_check("empty_status", '0, 1'b0, word);

		drain_wait = 0;
		while (checked != queued) begin
			drain_wait++;
			if (drain_wait > drain_limit) begin
				report_timeout("the checker did not finish the queued reads");
			end
			@(negedge clk);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
